/* source/rv_pkg.sv */
package rv_pkg;

    localparam int xlen      = 32;
    localparam int reg_count = 32;
    localparam int reg_aw    = $clog2(reg_count);  // register index width

    // funct3 codes of the integer ALU ops
    localparam logic [2:0] f3_add  = 3'b000;  // add, sub, addi
    localparam logic [2:0] f3_sll  = 3'b001;
    localparam logic [2:0] f3_slt  = 3'b010;
    localparam logic [2:0] f3_sltu = 3'b011;
    localparam logic [2:0] f3_xor  = 3'b100;
    localparam logic [2:0] f3_sr   = 3'b101;  // srl / sra
    localparam logic [2:0] f3_or   = 3'b110;
    localparam logic [2:0] f3_and  = 3'b111;

    // funct3 codes of the conditional branches
    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    localparam logic [2:0] f3_blt  = 3'b100;
    localparam logic [2:0] f3_bge  = 3'b101;
    localparam logic [2:0] f3_bltu = 3'b110;
    localparam logic [2:0] f3_bgeu = 3'b111;

    // major opcodes, inst[6:0]
    typedef enum logic [6:0] {
        op_r3    = 7'b0110011,  // register-register alu
        op_imm   = 7'b0010011,  // register-immediate alu
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011,
        op_ld    = 7'b0000011,  // decoded but not executed
        op_st    = 7'b0100011,  // decoded but not executed
        op_sys   = 7'b1110011   // ecall, ebreak, csr
    } opcode_t;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and
    } alu_op_t;

    // input packet, one instruction with its pc
    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [xlen-1:0] inst;
    } inst_pkt_t;

    // decode register contents
    typedef struct packed {
        logic [xlen-1:0]   pc;
        opcode_t           opcode;
        alu_op_t           alu_op;
        logic [2:0]        funct3;
        logic [reg_aw-1:0] rs1;
        logic [reg_aw-1:0] rs2;
        logic [reg_aw-1:0] rd;
        logic [xlen-1:0]   imm;        // sign extended
        logic              use_imm;    // imm replaces rs2 as operand b
        logic              writes_rd;  // low for x0 and for non-writing ops
        logic              illegal;
    } dec_pkt_t;

    // result packet, one per instruction
    typedef struct packed {
        logic [xlen-1:0]   pc;
        logic [reg_aw-1:0] rd;
        logic [xlen-1:0]   value;    // zero when wr_en is low
        logic              wr_en;
        logic [xlen-1:0]   next_pc;
        logic              taken;    // branch or jump redirect
        logic              illegal;
    } res_pkt_t;

endpackage

/* source/rv_decoder.sv */
`timescale 1ns/1ps

module rv_decoder (
    input  logic              clk,
    input  logic              reset,
    input  logic              in_valid,
    output logic              in_ready,
    input  rv_pkg::inst_pkt_t in_pkt,
    input  logic              res_free,
    output logic              dec_valid,
    output rv_pkg::dec_pkt_t  dec_pkt
);
    import rv_pkg::*;

    logic [xlen-1:0] inst;
    opcode_t         opcode;
    logic [2:0]      funct3;
    logic [4:0]      rd;
    logic            alt;  // funct7[5], also imm[10] on shifts
    logic            supported;
    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] imm_s;
    logic [xlen-1:0] imm_b;
    logic [xlen-1:0] imm_u;
    logic [xlen-1:0] imm_j;
    dec_pkt_t        dec_next;

    assign inst   = in_pkt.inst;
    assign opcode = opcode_t'(inst[6:0]);
    assign funct3 = inst[14:12];
    assign rd     = inst[11:7];
    assign alt    = inst[30];

    // immediate formats, all sign extended from inst[31]
    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        case (opcode)
            op_r3, op_imm, op_lui, op_auipc, op_jal, op_jalr, op_br: supported = 1'b1;
            default: supported = 1'b0;  // loads, stores, fence, system
        endcase
    end

    always_comb begin
        dec_next.pc        = in_pkt.pc;
        dec_next.opcode    = opcode;
        dec_next.funct3    = funct3;
        dec_next.rs1       = inst[19:15];
        dec_next.rs2       = inst[24:20];
        dec_next.rd        = rd;
        dec_next.illegal   = !supported;
        dec_next.writes_rd = supported && (opcode != op_br) && (rd != '0);

        case (opcode)
            op_imm, op_jalr, op_ld: dec_next.imm = imm_i;
            op_st:                  dec_next.imm = imm_s;
            op_br:                  dec_next.imm = imm_b;
            op_lui, op_auipc:       dec_next.imm = imm_u;
            op_jal:                 dec_next.imm = imm_j;
            default:                dec_next.imm = '0;
        endcase

        // jalr goes through the adder with its immediate
        dec_next.use_imm = (opcode == op_imm) || (opcode == op_jalr) ||
                           (opcode == op_ld) || (opcode == op_st);

        dec_next.alu_op = alu_add;
        if (opcode == op_r3 || opcode == op_imm) begin
            case (funct3)
                f3_add:  dec_next.alu_op = (opcode == op_r3 && alt) ? alu_sub : alu_add;
                f3_sll:  dec_next.alu_op = alu_sll;
                f3_slt:  dec_next.alu_op = alu_slt;
                f3_sltu: dec_next.alu_op = alu_sltu;
                f3_xor:  dec_next.alu_op = alu_xor;
                f3_sr:   dec_next.alu_op = alt ? alu_sra : alu_srl;
                f3_or:   dec_next.alu_op = alu_or;
                f3_and:  dec_next.alu_op = alu_and;
                default: dec_next.alu_op = alu_add;
            endcase
        end
    end

    // register is free when empty or when its content moves on this edge
    assign in_ready = !dec_valid || res_free;

    always_ff @(posedge clk) begin
        if (reset) begin
            dec_valid <= 1'b0;
            dec_pkt   <= '0;
        end else if (in_ready) begin
            dec_valid <= in_valid;
            if (in_valid) begin
                dec_pkt <= dec_next;
            end
        end
    end

endmodule

/* source/rv_execute.sv */
`timescale 1ns/1ps

module rv_execute (
    input  rv_pkg::dec_pkt_t dec_pkt,
    input  logic [31:0]      rf_rs1_data,
    input  logic [31:0]      rf_rs2_data,
    input  logic             pend_wr_en,
    input  logic [4:0]       pend_rd,
    input  logic [31:0]      pend_value,
    output logic [4:0]       rf_rs1_addr,
    output logic [4:0]       rf_rs2_addr,
    output rv_pkg::res_pkt_t exe_pkt
);
    import rv_pkg::*;

    logic [xlen-1:0] rs1_val;
    logic [xlen-1:0] rs2_val;
    logic [xlen-1:0] op_b;
    logic [4:0]      shamt;
    logic [xlen-1:0] alu_out;
    logic [xlen-1:0] seq_pc;
    logic [xlen-1:0] pc_imm;   // auipc value, jal and branch target
    logic [xlen-1:0] result;
    logic [xlen-1:0] next_pc;
    logic            br_cond;
    logic            taken;

    assign rf_rs1_addr = dec_pkt.rs1;
    assign rf_rs2_addr = dec_pkt.rs2;

    // the held result is not in the file yet, so it wins
    assign rs1_val = (pend_wr_en && pend_rd == dec_pkt.rs1) ? pend_value : rf_rs1_data;
    assign rs2_val = (pend_wr_en && pend_rd == dec_pkt.rs2) ? pend_value : rf_rs2_data;

    assign op_b   = dec_pkt.use_imm ? dec_pkt.imm : rs2_val;
    assign shamt  = op_b[4:0];
    assign seq_pc = dec_pkt.pc + 32'd4;
    assign pc_imm = dec_pkt.pc + dec_pkt.imm;

    always_comb begin
        case (dec_pkt.alu_op)
            alu_add:  alu_out = rs1_val + op_b;
            alu_sub:  alu_out = rs1_val - op_b;
            alu_sll:  alu_out = rs1_val << shamt;
            alu_slt:  alu_out = {31'b0, $signed(rs1_val) < $signed(op_b)};
            alu_sltu: alu_out = {31'b0, rs1_val < op_b};
            alu_xor:  alu_out = rs1_val ^ op_b;
            alu_srl:  alu_out = rs1_val >> shamt;
            alu_sra:  alu_out = $signed(rs1_val) >>> shamt;
            alu_or:   alu_out = rs1_val | op_b;
            alu_and:  alu_out = rs1_val & op_b;
            default:  alu_out = '0;
        endcase
    end

    always_comb begin
        case (dec_pkt.funct3)
            f3_beq:  br_cond = (rs1_val == rs2_val);
            f3_bne:  br_cond = (rs1_val != rs2_val);
            f3_blt:  br_cond = ($signed(rs1_val) < $signed(rs2_val));
            f3_bge:  br_cond = ($signed(rs1_val) >= $signed(rs2_val));
            f3_bltu: br_cond = (rs1_val < rs2_val);
            f3_bgeu: br_cond = (rs1_val >= rs2_val);
            default: br_cond = 1'b0;  // reserved encodings fall through
        endcase
    end

    always_comb begin
        result  = alu_out;
        next_pc = seq_pc;
        taken   = 1'b0;
        case (dec_pkt.opcode)
            op_lui:   result = dec_pkt.imm;
            op_auipc: result = pc_imm;
            op_jal: begin
                result  = seq_pc;  // link
                next_pc = pc_imm;
                taken   = 1'b1;
            end
            op_jalr: begin
                result  = seq_pc;
                next_pc = {alu_out[31:1], 1'b0};  // target bit 0 dropped
                taken   = 1'b1;
            end
            op_br: begin
                if (br_cond) begin
                    next_pc = pc_imm;
                    taken   = 1'b1;
                end
            end
            default: ;  // alu ops keep alu_out, illegal ops just step
        endcase
    end

    always_comb begin
        exe_pkt.pc      = dec_pkt.pc;
        exe_pkt.wr_en   = dec_pkt.writes_rd;
        exe_pkt.rd      = dec_pkt.writes_rd ? dec_pkt.rd : '0;
        exe_pkt.value   = dec_pkt.writes_rd ? result : '0;
        exe_pkt.next_pc = next_pc;
        exe_pkt.taken   = taken;
        exe_pkt.illegal = dec_pkt.illegal;
    end

endmodule

/* source/rv_result.sv */
`timescale 1ns/1ps

module rv_result (
    input  logic             clk,
    input  logic             reset,
    input  logic             dec_valid,
    input  rv_pkg::res_pkt_t exe_pkt,
    input  logic             out_ready,
    input  logic [4:0]       rf_rs1_addr,
    input  logic [4:0]       rf_rs2_addr,
    output logic             out_valid,
    output rv_pkg::res_pkt_t out_pkt,
    output logic             res_free,
    output logic [31:0]      rf_rs1_data,
    output logic [31:0]      rf_rs2_data,
    output logic             pend_wr_en,
    output logic [4:0]       pend_rd,
    output logic [31:0]      pend_value
);
    import rv_pkg::*;

    logic [xlen-1:0] regs [reg_count];
    logic            accept;

    assign accept   = out_valid && out_ready;
    assign res_free = !out_valid || out_ready;  // empty or leaving now

    // output register, loads only when free so a stalled result holds
    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
            out_pkt   <= '0;
        end else if (res_free) begin
            out_valid <= dec_valid;
            if (dec_valid) begin
                out_pkt <= exe_pkt;
            end
        end
    end

    // writes land when the result leaves, keeping program order
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (accept && out_pkt.wr_en && out_pkt.rd != '0) begin
            regs[out_pkt.rd] <= out_pkt.value;
        end
    end

    // x0 reads as zero whatever the array holds
    assign rf_rs1_data = (rf_rs1_addr == '0) ? '0 : regs[rf_rs1_addr];
    assign rf_rs2_data = (rf_rs2_addr == '0) ? '0 : regs[rf_rs2_addr];

    // held result not yet committed, for the execute bypass
    assign pend_wr_en = out_valid && out_pkt.wr_en;
    assign pend_rd    = out_pkt.rd;
    assign pend_value = out_pkt.value;

endmodule

/* source/rv_exec_unit.sv */
`timescale 1ns/1ps

module rv_exec_unit (
    input  logic              clk,
    input  logic              reset,
    input  logic              in_valid,
    output logic              in_ready,
    input  rv_pkg::inst_pkt_t in_pkt,
    output logic              out_valid,
    input  logic              out_ready,
    output rv_pkg::res_pkt_t  out_pkt
);
    import rv_pkg::*;

    logic            dec_valid;
    dec_pkt_t        dec_pkt;
    res_pkt_t        exe_pkt;
    logic            res_free;  // stall control back to decode
    logic [4:0]      rf_rs1_addr;
    logic [4:0]      rf_rs2_addr;
    logic [xlen-1:0] rf_rs1_data;
    logic [xlen-1:0] rf_rs2_data;
    logic            pend_wr_en;
    logic [4:0]      pend_rd;
    logic [xlen-1:0] pend_value;

    rv_decoder u_rv_decoder (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_pkt    (in_pkt),
        .res_free  (res_free),
        .dec_valid (dec_valid),
        .dec_pkt   (dec_pkt)
    );

    rv_execute u_rv_execute (
        .dec_pkt     (dec_pkt),
        .rf_rs1_data (rf_rs1_data),
        .rf_rs2_data (rf_rs2_data),
        .pend_wr_en  (pend_wr_en),
        .pend_rd     (pend_rd),
        .pend_value  (pend_value),
        .rf_rs1_addr (rf_rs1_addr),
        .rf_rs2_addr (rf_rs2_addr),
        .exe_pkt     (exe_pkt)
    );

    rv_result u_rv_result (
        .clk         (clk),
        .reset       (reset),
        .dec_valid   (dec_valid),
        .exe_pkt     (exe_pkt),
        .out_ready   (out_ready),
        .rf_rs1_addr (rf_rs1_addr),
        .rf_rs2_addr (rf_rs2_addr),
        .out_valid   (out_valid),
        .out_pkt     (out_pkt),
        .res_free    (res_free),
        .rf_rs1_data (rf_rs1_data),
        .rf_rs2_data (rf_rs2_data),
        .pend_wr_en  (pend_wr_en),
        .pend_rd     (pend_rd),
        .pend_value  (pend_value)
    );

endmodule

/* sim/rv_exec_unit_chk.sv */
`timescale 1ns/1ps

module rv_exec_unit_chk (
    input logic             clk,
    input logic             reset,
    input logic             in_ready,
    input logic             out_valid,
    input logic             out_ready,
    input rv_pkg::res_pkt_t out_pkt
);

    // stalled result holds still
    out_hold: assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(out_pkt))
        else $error("out_pkt or out_valid changed while out_ready was low");

    ready_after_reset: assert property (@(posedge clk) $fell(reset) |-> in_ready)
        else $error("in_ready low in the first cycle after reset");

    quiet_in_reset: assert property (@(posedge clk) reset |=> !out_valid)
        else $error("out_valid high during reset");

    // x0 is never a write target
    no_x0_write: assert property (@(posedge clk) disable iff (reset)
        out_valid |-> !(out_pkt.wr_en && out_pkt.rd == 5'd0))
        else $error("result writes register x0");

endmodule

bind rv_exec_unit rv_exec_unit_chk u_rv_exec_unit_chk (
    .clk       (clk),
    .reset     (reset),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_pkt   (out_pkt)
);

/* sim/rv_exec_unit_tb.sv */
`timescale 1ns/1ps

module rv_exec_unit_tb;
    import rv_pkg::*;

    localparam int          clk_period   = 10;
    localparam int          reset_cycles = 16;
    localparam int          steady_count = 40;   // back to back, out_ready held high
    localparam int          total_count  = 440;
    localparam logic [31:0] start_pc     = 32'h0000_1000;

    logic      clk;
    logic      reset;
    logic      in_valid;
    logic      in_ready;
    inst_pkt_t in_pkt;
    logic      out_valid;
    logic      out_ready;
    res_pkt_t  out_pkt;

    logic [31:0] rf_model [32];  // architectural registers of the model
    logic [31:0] model_pc;
    res_pkt_t    exp_q [$];
    logic        in_fired;       // input taken at the last rising edge
    int          n_target;
    int          n_sent;
    int          n_checked;
    int          cyc;
    int          first_in_cyc;
    int          first_out_cyc;

    rv_exec_unit u_rv_exec_unit (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_pkt    (in_pkt),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_pkt   (out_pkt)
    );

    always #(clk_period / 2) clk = ~clk;

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Test failures found");
        $fatal(1, "simulation stopped at the first error");
    endtask

    // mostly x0..x7 so that neighbours depend on each other
    function automatic logic [4:0] pick_reg();
        if ($urandom_range(0, 9) < 7) return 5'($urandom_range(0, 7));
        return 5'($urandom_range(0, 31));
    endfunction

    function automatic logic [31:0] gen_inst();
        int unsigned kind;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] imm12;
        logic [31:0] inst;

        kind  = $urandom_range(0, 99);
        rd    = pick_reg();
        rs1   = pick_reg();
        rs2   = pick_reg();
        f3    = 3'($urandom_range(0, 7));
        f7    = ($urandom_range(0, 1) == 1) ? 7'b0100000 : 7'b0000000;
        imm12 = 12'($urandom);
        if (kind < 30) begin
            if (f3 != 3'b000 && f3 != 3'b101) f7 = 7'b0;  // only sub and sra use funct7
            inst = {f7, rs2, rs1, f3, rd, op_r3};
        end else if (kind < 55) begin
            if (f3 == 3'b001) imm12[11:5] = 7'b0;        // slli
            else if (f3 == 3'b101) imm12[11:5] = f7;     // srli or srai
            inst = {imm12, rs1, f3, rd, op_imm};
        end else if (kind < 62) begin
            inst = {20'($urandom), rd, op_lui};
        end else if (kind < 68) begin
            inst = {20'($urandom), rd, op_auipc};
        end else if (kind < 73) begin
            inst = {20'($urandom), rd, op_jal};
        end else if (kind < 78) begin
            inst = {imm12, rs1, 3'b000, rd, op_jalr};
        end else if (kind < 92) begin
            // 0,1 stay, 2..5 map onto blt..bgeu
            f3 = 3'($urandom_range(0, 5));
            if (f3 >= 3'd2) f3 = f3 + 3'd2;
            inst = {7'($urandom), rs2, rs1, f3, 5'($urandom), op_br};
        end else if (kind < 95) begin
            inst = {imm12, rs1, f3, rd, op_ld};
        end else if (kind < 98) begin
            inst = {imm12[11:5], rs2, rs1, f3, imm12[4:0], op_st};
        end else begin
            inst = {12'($urandom), rs1, f3, rd, op_sys};
        end
        return inst;
    endfunction

    function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic alt,
                                              input logic reg_op, input logic [31:0] a,
                                              input logic [31:0] b);
        logic [31:0] res;

        case (f3)
            3'b000: res = (reg_op && alt) ? a - b : a + b;
            3'b001: res = a << b[4:0];
            3'b010: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011: res = (a < b) ? 32'd1 : 32'd0;
            3'b100: res = a ^ b;
            3'b101: begin
                if (alt) res = $signed(a) >>> b[4:0];
                else res = a >> b[4:0];
            end
            3'b110: res = a | b;
            default: res = a & b;
        endcase
        return res;
    endfunction

    // one instruction in program order, updates model state
    task automatic model_step(input logic [31:0] pc, input logic [31:0] inst,
                              output res_pkt_t want);
        logic [4:0]  rd;
        logic [2:0]  f3;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] imm_b;
        logic [31:0] imm_j;
        logic [31:0] imm_u;
        logic [31:0] val;
        logic [31:0] npc;
        logic        wr;
        logic        tk;
        logic        ill;
        logic        cond;

        rd    = inst[11:7];
        f3    = inst[14:12];
        a     = rf_model[inst[19:15]];
        b     = rf_model[inst[24:20]];
        imm_i = {{20{inst[31]}}, inst[31:20]};
        imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
        imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
        imm_u = {inst[31:12], 12'h000};
        val   = '0;
        npc   = pc + 32'd4;
        wr    = 1'b0;
        tk    = 1'b0;
        ill   = 1'b0;
        cond  = 1'b0;
        case (inst[6:0])
            op_r3: begin
                wr  = 1'b1;
                val = alu_model(f3, inst[30], 1'b1, a, b);
            end
            op_imm: begin
                wr  = 1'b1;
                val = alu_model(f3, inst[30], 1'b0, a, imm_i);
            end
            op_lui: begin
                wr  = 1'b1;
                val = imm_u;
            end
            op_auipc: begin
                wr  = 1'b1;
                val = pc + imm_u;
            end
            op_jal: begin
                wr  = 1'b1;
                val = pc + 32'd4;
                npc = pc + imm_j;
                tk  = 1'b1;
            end
            op_jalr: begin
                wr  = 1'b1;
                val = pc + 32'd4;
                npc = (a + imm_i) & 32'hffff_fffe;
                tk  = 1'b1;
            end
            op_br: begin
                case (f3)
                    3'b000: cond = (a == b);
                    3'b001: cond = (a != b);
                    3'b100: cond = ($signed(a) < $signed(b));
                    3'b101: cond = ($signed(a) >= $signed(b));
                    3'b110: cond = (a < b);
                    3'b111: cond = (a >= b);
                    default: cond = 1'b0;
                endcase
                if (cond) begin
                    npc = pc + imm_b;
                    tk  = 1'b1;
                end
            end
            default: ill = 1'b1;  // loads, stores, system
        endcase
        if (rd == 5'd0) wr = 1'b0;  // x0 drops the write

        want.pc      = pc;
        want.rd      = wr ? rd : 5'd0;
        want.value   = wr ? val : 32'd0;
        want.wr_en   = wr;
        want.next_pc = npc;
        want.taken   = tk;
        want.illegal = ill;
        if (wr) rf_model[rd] = val;
        model_pc = npc;
    endtask

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] want, input logic [31:0] pc);
        assert (got === want) else begin
            report_failure($sformatf("FAILED at %0d ns: %s is %h, expected %h, pc %h",
                                     $time, name, got, want, pc));
        end
    endtask

    task automatic check_result();
        res_pkt_t want;

        assert (exp_q.size() != 0) else begin
            report_failure("a result came out with no instruction outstanding");
        end
        want = exp_q.pop_front();
        check_field("pc", out_pkt.pc, want.pc, want.pc);
        check_field("rd", 32'(out_pkt.rd), 32'(want.rd), want.pc);
        check_field("value", out_pkt.value, want.value, want.pc);
        check_field("wr_en", 32'(out_pkt.wr_en), 32'(want.wr_en), want.pc);
        check_field("next_pc", out_pkt.next_pc, want.next_pc, want.pc);
        check_field("taken", 32'(out_pkt.taken), 32'(want.taken), want.pc);
        check_field("illegal", 32'(out_pkt.illegal), 32'(want.illegal), want.pc);
        n_checked++;
    endtask

    // drive at the falling edge, sample just before the rising edge
    task automatic run_cycle(input bit gaps, input bit stalls);
        res_pkt_t want;

        @(negedge clk);
        if (in_fired) begin
            in_valid = 1'b0;
            in_fired = 1'b0;
        end
        if (!in_valid && n_sent < n_target) begin
            if (!gaps || $urandom_range(0, 3) != 0) begin
                in_pkt.pc   = model_pc;
                in_pkt.inst = gen_inst();
                in_valid    = 1'b1;
            end
        end
        out_ready = stalls ? ($urandom_range(0, 3) != 0) : 1'b1;
        #(clk_period / 2 - 1);
        if (out_valid && first_out_cyc < 0) first_out_cyc = cyc;
        if (out_valid && out_ready) check_result();
        if (in_valid && in_ready) begin
            model_step(in_pkt.pc, in_pkt.inst, want);
            exp_q.push_back(want);
            n_sent++;
            in_fired = 1'b1;
            if (first_in_cyc < 0) first_in_cyc = cyc;
        end
        cyc++;
    endtask

    initial begin
        void'($urandom(3449));
        clk           = 1'b0;
        reset         = 1'b1;
        in_valid      = 1'b0;
        in_pkt        = '0;
        out_ready     = 1'b0;
        in_fired      = 1'b0;
        n_target      = 0;
        n_sent        = 0;
        n_checked     = 0;
        cyc           = 0;
        first_in_cyc  = -1;
        first_out_cyc = -1;
        model_pc      = start_pc;
        for (int i = 0; i < 32; i++) rf_model[i] = '0;

        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // steady stream first, latency is measured here
        n_target = steady_count;
        while (n_sent < n_target) run_cycle(1'b0, 1'b0);
        assert (first_out_cyc == first_in_cyc + 2) else begin
            report_failure($sformatf(
                "FAILED at %0d ns: first result %0d cycles after input, expected 2",
                $time, first_out_cyc - first_in_cyc));
        end

        n_target = total_count;
        while (n_sent < n_target) run_cycle(1'b1, 1'b1);
        while (exp_q.size() != 0) run_cycle(1'b1, 1'b1);  // drain
        repeat (4) run_cycle(1'b0, 1'b0);  // no result may follow the last one

        $display("All tests passed!");
        $finish;
    end

    // 20 cycles per instruction on top of reset
    initial begin
        #((reset_cycles + 20 * total_count) * clk_period);
        report_failure($sformatf(
            "watchdog expired with %0d of %0d instructions sent, the run hung",
            n_sent, total_count));
    end

endmodule

/* rv_exec_unit.f */
source/rv_pkg.sv
source/rv_decoder.sv
source/rv_execute.sv
source/rv_result.sv
source/rv_exec_unit.sv
sim/rv_exec_unit_chk.sv
sim/rv_exec_unit_tb.sv

/* run.sh */
#!/bin/sh
# build the testbench with verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f rv_exec_unit.f \
    --top-module rv_exec_unit_tb -o rv_exec_unit_sim || exit 1

out=$(./obj_dir/rv_exec_unit_sim 2>&1)
echo "$out"
echo "$out" | grep -q '^All tests passed!$' && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
